// File: src.f
+incdir+hdl
hdl/rv32i_pkg.sv
hdl/alu.sv
hdl/cmp.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/exec_core.sv
bench/exec_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exec_core_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status of the simulation is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/exec_core_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv32i_config.svh"

module exec_core_tb
import rv32i_pkg::*;
();

    localparam int num_slots  = 400;  // input cycles, idle ones included
    localparam int clk_period = 100;

    // one expected output slot
    typedef struct packed {
        logic [31:0]           stamp;  // cycle count when the input was driven
        logic [`XLEN-1:0]      order;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      pc_next;
        logic [`XLEN-1:0]      alu;
        logic [`XLEN-1:0]      rs2_v;
        logic [`REG_IDX_W-1:0] rd;
        wb_sel_t               wb_sel;
        logic                  alu_known;
        logic                  br_en;
        logic                  br_known;
        logic                  wb_en;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  illegal;
    } expect_t;

    logic                  clk, rst;
    logic                  in_valid;
    logic [31:0]           in_inst;
    logic [`XLEN-1:0]      in_pc, in_order, in_rs1_v, in_rs2_v;
    logic                  out_valid;
    logic [`XLEN-1:0]      out_pc, out_pc_next, out_order, out_alu, out_rs2_v;
    logic [`REG_IDX_W-1:0] out_rd;
    logic                  out_br_en, out_wb_en, out_mem_rd, out_mem_wr, out_illegal;
    wb_sel_t               out_wb_sel;

    logic [31:0] lfsr_state = 32'h7f29;
    logic [31:0] cycle = 32'd0;
    expect_t     pending[$];
    int          checked = 0;

    exec_core dut_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_pc       (in_pc),
        .in_order    (in_order),
        .in_rs1_v    (in_rs1_v),
        .in_rs2_v    (in_rs2_v),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_pc_next (out_pc_next),
        .out_order   (out_order),
        .out_rd      (out_rd),
        .out_alu     (out_alu),
        .out_br_en   (out_br_en),
        .out_rs2_v   (out_rs2_v),
        .out_wb_sel  (out_wb_sel),
        .out_wb_en   (out_wb_en),
        .out_mem_rd  (out_mem_rd),
        .out_mem_wr  (out_mem_wr),
        .out_illegal (out_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 32'd1;

    // fibonacci lfsr with taps 32 22 2 1, stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] make_inst();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [19:0] imm20;
        kind  = 4'(take_bits(4));
        f3    = 3'(take_bits(3));
        rd    = 5'(take_bits(5));
        rs1   = 5'(take_bits(5));
        rs2   = 5'(take_bits(5));
        f7    = (take_bits(1) != 0) ? 7'h20 : 7'h00;
        imm12 = 12'(take_bits(12));
        imm20 = 20'(take_bits(20));
        if (take_bits(3) == 0)
            rd = 5'd0;  // x0 targets show up more often
        case (kind)
            4'd0, 4'd1: begin
                if (f3 != 3'b000 && f3 != 3'b101)
                    f7 = 7'h00;
                return {f7, rs2, rs1, f3, rd, 7'b0110011};
            end
            4'd2, 4'd3, 4'd15: begin
                if (f3 == 3'b001)
                    imm12[11:5] = 7'h00;
                else if (f3 == 3'b101)
                    imm12[11:5] = f7;  // srli or srai
                return {imm12, rs1, f3, rd, 7'b0010011};
            end
            4'd4:  return {imm20, rd, 7'b0110111};
            4'd5:  return {imm20, rd, 7'b0010111};
            4'd6:  return {imm20, rd, 7'b1101111};
            4'd7:  return {imm12, rs1, 3'b000, rd, 7'b1100111};
            4'd8, 4'd9: begin
                if (f3[2:1] == 2'b01)
                    f3[1] = 1'b0;  // no branch at 010 and 011
                return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b1100011};
            end
            4'd10, 4'd11: return {imm12, rs1, f3, rd, 7'b0000011};
            4'd12, 4'd13: return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
            default: begin
                // fence, system and two unused encodings
                case (f3[1:0])
                    2'b00:   return {imm20, rd, 7'b0001111};
                    2'b01:   return {imm20, rd, 7'b1110011};
                    2'b10:   return {imm20, rd, 7'b0000000};
                    default: return {imm20, rd, 7'b1111111};
                endcase
            end
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] arith_result(input logic [2:0] f3, input logic alt,
            input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << sh;
            3'b100:  return a ^ b;
            3'b101:  return (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3,
            input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // expected out_ slot from the instruction rules of rv32i
    function automatic expect_t model_result(input logic [31:0] inst,
            input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] rs1,
            input logic [`XLEN-1:0] rs2, input logic [`XLEN-1:0] order);
        expect_t          e;
        logic [2:0]       f3;
        logic [`XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;
        f3    = inst[14:12];
        i_imm = {{20{inst[31]}}, inst[31:20]};
        s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        u_imm = {inst[31:12], 12'h000};
        j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        e           = '0;
        e.order     = order;
        e.pc        = pc;
        e.pc_next   = pc + 32'd4;
        e.rs2_v     = rs2;
        e.rd        = inst[11:7];
        e.wb_sel    = wb_alu;
        e.wb_en     = (inst[11:7] != 5'd0);
        e.alu_known = 1'b1;
        case (inst[6:0])
            7'b0110011, 7'b0010011: begin
                if (f3[2:1] == 2'b01) begin  // slt, sltu and immediate forms
                    e.wb_sel    = wb_cmp;
                    e.alu_known = 1'b0;
                    e.br_known  = 1'b1;
                    e.br_en     = branch_taken(f3[0] ? 3'b110 : 3'b100, rs1,
                                               inst[5] ? rs2 : i_imm);
                end else if (inst[5]) begin
                    e.alu = arith_result(f3, inst[30], rs1, rs2);
                end else begin
                    e.alu = arith_result(f3, inst[30] && f3 == 3'b101, rs1, i_imm);
                end
            end
            7'b0110111: e.alu = u_imm;
            7'b0010111: e.alu = pc + u_imm;
            7'b1101111: begin
                e.alu    = pc + j_imm;
                e.wb_sel = wb_pc_next;
            end
            7'b1100111: begin
                e.alu    = rs1 + i_imm;
                e.wb_sel = wb_pc_next;
            end
            7'b1100011: begin
                e.alu      = pc + b_imm;
                e.br_known = 1'b1;
                e.br_en    = branch_taken(f3, rs1, rs2);
                e.wb_sel   = wb_none;
                e.wb_en    = 1'b0;
            end
            7'b0000011: begin
                e.alu    = rs1 + i_imm;
                e.wb_sel = wb_mem;
                e.mem_rd = 1'b1;
            end
            7'b0100011: begin
                e.alu    = rs1 + s_imm;
                e.wb_sel = wb_none;
                e.wb_en  = 1'b0;
                e.mem_wr = 1'b1;
            end
            default: begin
                e.illegal   = 1'b1;
                e.alu_known = 1'b0;
                e.wb_sel    = wb_none;
                e.wb_en     = 1'b0;
            end
        endcase
        return e;
    endfunction

    task automatic report_failure();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got,
            input logic [`XLEN-1:0] want);
        if (got !== want) begin
            $display("ERROR %s: got %h, expected %h", name, got, want);
            report_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERROR %s: got %h, expected %h", name, got, want);
            report_failure();
        end
    endtask

    task automatic check_wb_sel(input string name, input wb_sel_t got, input wb_sel_t want);
        if (got !== want) begin
            $display("ERROR %s: got %h, expected %h", name, got, want);
            report_failure();
        end
    endtask

    task automatic check_rd(input string name, input logic [`REG_IDX_W-1:0] got,
            input logic [`REG_IDX_W-1:0] want);
        if (got !== want) begin
            $display("ERROR %s: got %h, expected %h", name, got, want);
            report_failure();
        end
    endtask

    task automatic check_idle_outputs();
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("out_wb_en", out_wb_en, 1'b0);
        check_flag("out_mem_rd", out_mem_rd, 1'b0);
        check_flag("out_mem_wr", out_mem_wr, 1'b0);
    endtask

    task automatic compare_slot(input expect_t e);
        check_word("out_order", out_order, e.order);  // a lost slot shows up here first
        check_word("out_pc", out_pc, e.pc);
        check_word("out_pc_next", out_pc_next, e.pc_next);
        check_rd("out_rd", out_rd, e.rd);
        if (e.alu_known)
            check_word("out_alu", out_alu, e.alu);
        if (e.br_known)
            check_flag("out_br_en", out_br_en, e.br_en);
        check_word("out_rs2_v", out_rs2_v, e.rs2_v);
        check_wb_sel("out_wb_sel", out_wb_sel, e.wb_sel);
        check_flag("out_wb_en", out_wb_en, e.wb_en);
        check_flag("out_mem_rd", out_mem_rd, e.mem_rd);
        check_flag("out_mem_wr", out_mem_wr, e.mem_wr);
        check_flag("out_illegal", out_illegal, e.illegal);
    endtask

    // outputs are sampled mid cycle
    always @(negedge clk) begin
        expect_t e;
        if (!rst) begin
            if (out_valid === 1'b1) begin
                if (pending.size() == 0) begin
                    $display("out_valid was high with no instruction outstanding");
                    report_failure();
                end else begin
                    e = pending.pop_front();
                    if (cycle != e.stamp + 32'd2) begin
                        $display("instruction %0d came out after the wrong number of cycles",
                                 e.order);
                        report_failure();
                    end else begin
                        compare_slot(e);
                        checked++;
                    end
                end
            end else if (pending.size() != 0 && pending[0].stamp + 32'd2 == cycle) begin
                $display("instruction %0d did not come out on time", pending[0].order);
                report_failure();
            end
        end
    end

    initial begin
        expect_t          e;
        logic [31:0]      inst;
        logic [`XLEN-1:0] pc, rs1, rs2;
        logic [`XLEN-1:0] order_num;
        order_num = '0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_inst   = '0;
        in_pc     = '0;
        in_order  = '0;
        in_rs1_v  = '0;
        in_rs2_v  = '0;
        @(posedge clk);
        #10;
        check_idle_outputs();
        @(posedge clk);
        #10;
        check_idle_outputs();
        rst = 1'b0;
        @(posedge clk);
        #10;
        check_idle_outputs();
        for (int slot = 0; slot < num_slots; slot++) begin
            if (take_bits(3) != 0) begin
                inst = make_inst();
                pc   = take_bits(30) << 2;
                rs1  = take_bits(32);
                rs2  = (take_bits(2) == 0) ? rs1 : take_bits(32);  // equal operands for beq
                in_valid = 1'b1;
                in_inst  = inst;
                in_pc    = pc;
                in_order = order_num;
                in_rs1_v = rs1;
                in_rs2_v = rs2;
                e = model_result(inst, pc, rs1, rs2, order_num);
                e.stamp = cycle;
                pending.push_back(e);
                order_num++;
            end else begin
                in_valid = 1'b0;
            end
            @(posedge clk);
            #10;
        end
        in_valid = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        #10;
        if (pending.size() != 0) begin
            $display("%0d instructions never came out", pending.size());
            report_failure();
        end else begin
            $display("%0d instructions checked", checked);
            $display("*** PASSED ***");
            $finish;
        end
    end

    initial begin
        #((num_slots + 20) * clk_period);
        $display("watchdog expired before the run finished");
        report_failure();
    end

endmodule

`default_nettype wire

// File: hdl/exec_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv32i_config.svh"

module exec_core
import rv32i_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic [31:0]           in_inst,
    input  logic [`XLEN-1:0]      in_pc,
    input  logic [`XLEN-1:0]      in_order,
    input  logic [`XLEN-1:0]      in_rs1_v,
    input  logic [`XLEN-1:0]      in_rs2_v,
    output logic                  out_valid,
    output logic [`XLEN-1:0]      out_pc,
    output logic [`XLEN-1:0]      out_pc_next,
    output logic [`XLEN-1:0]      out_order,
    output logic [`REG_IDX_W-1:0] out_rd,
    output logic [`XLEN-1:0]      out_alu,
    output logic                  out_br_en,
    output logic [`XLEN-1:0]      out_rs2_v,
    output wb_sel_t               out_wb_sel,
    output logic                  out_wb_en,
    output logic                  out_mem_rd,
    output logic                  out_mem_wr,
    output logic                  out_illegal
);

    // id/ex stage register
    logic                  id_ex_valid;
    logic [`XLEN-1:0]      id_ex_pc, id_ex_pc_next, id_ex_order;
    logic [`REG_IDX_W-1:0] id_ex_rd;
    logic [`XLEN-1:0]      id_ex_rs1_v, id_ex_rs2_v, id_ex_imm;
    alu_m1_sel_t           id_ex_alu_m1_sel;
    alu_m2_sel_t           id_ex_alu_m2_sel;
    cmp_sel_t              id_ex_cmp_sel;
    alu_op_t               id_ex_aluop;
    cmp_op_t               id_ex_cmpop;
    wb_sel_t               id_ex_wb_sel;
    logic                  id_ex_wb_en, id_ex_mem_rd, id_ex_mem_wr, id_ex_illegal;

    decode_stage decode_i (
        .clk              (clk),
        .rst              (rst),
        .in_valid         (in_valid),
        .in_inst          (in_inst),
        .in_pc            (in_pc),
        .in_order         (in_order),
        .in_rs1_v         (in_rs1_v),
        .in_rs2_v         (in_rs2_v),
        .id_ex_valid      (id_ex_valid),
        .id_ex_pc         (id_ex_pc),
        .id_ex_pc_next    (id_ex_pc_next),
        .id_ex_order      (id_ex_order),
        .id_ex_rd         (id_ex_rd),
        .id_ex_rs1_v      (id_ex_rs1_v),
        .id_ex_rs2_v      (id_ex_rs2_v),
        .id_ex_imm        (id_ex_imm),
        .id_ex_alu_m1_sel (id_ex_alu_m1_sel),
        .id_ex_alu_m2_sel (id_ex_alu_m2_sel),
        .id_ex_cmp_sel    (id_ex_cmp_sel),
        .id_ex_aluop      (id_ex_aluop),
        .id_ex_cmpop      (id_ex_cmpop),
        .id_ex_wb_sel     (id_ex_wb_sel),
        .id_ex_wb_en      (id_ex_wb_en),
        .id_ex_mem_rd     (id_ex_mem_rd),
        .id_ex_mem_wr     (id_ex_mem_wr),
        .id_ex_illegal    (id_ex_illegal)
    );

    execute_stage execute_i (
        .clk              (clk),
        .rst              (rst),
        .id_ex_valid      (id_ex_valid),
        .id_ex_pc         (id_ex_pc),
        .id_ex_pc_next    (id_ex_pc_next),
        .id_ex_order      (id_ex_order),
        .id_ex_rd         (id_ex_rd),
        .id_ex_rs1_v      (id_ex_rs1_v),
        .id_ex_rs2_v      (id_ex_rs2_v),
        .id_ex_imm        (id_ex_imm),
        .id_ex_alu_m1_sel (id_ex_alu_m1_sel),
        .id_ex_alu_m2_sel (id_ex_alu_m2_sel),
        .id_ex_cmp_sel    (id_ex_cmp_sel),
        .id_ex_aluop      (id_ex_aluop),
        .id_ex_cmpop      (id_ex_cmpop),
        .id_ex_wb_sel     (id_ex_wb_sel),
        .id_ex_wb_en      (id_ex_wb_en),
        .id_ex_mem_rd     (id_ex_mem_rd),
        .id_ex_mem_wr     (id_ex_mem_wr),
        .id_ex_illegal    (id_ex_illegal),
        .out_valid        (out_valid),
        .out_pc           (out_pc),
        .out_pc_next      (out_pc_next),
        .out_order        (out_order),
        .out_rd           (out_rd),
        .out_alu          (out_alu),
        .out_br_en        (out_br_en),
        .out_rs2_v        (out_rs2_v),
        .out_wb_sel       (out_wb_sel),
        .out_wb_en        (out_wb_en),
        .out_mem_rd       (out_mem_rd),
        .out_mem_wr       (out_mem_wr),
        .out_illegal      (out_illegal)
    );

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv32i_config.svh"

module execute_stage
import rv32i_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_ex_valid,
    input  logic [`XLEN-1:0]      id_ex_pc,
    input  logic [`XLEN-1:0]      id_ex_pc_next,
    input  logic [`XLEN-1:0]      id_ex_order,
    input  logic [`REG_IDX_W-1:0] id_ex_rd,
    input  logic [`XLEN-1:0]      id_ex_rs1_v,
    input  logic [`XLEN-1:0]      id_ex_rs2_v,
    input  logic [`XLEN-1:0]      id_ex_imm,
    input  alu_m1_sel_t           id_ex_alu_m1_sel,
    input  alu_m2_sel_t           id_ex_alu_m2_sel,
    input  cmp_sel_t              id_ex_cmp_sel,
    input  alu_op_t               id_ex_aluop,
    input  cmp_op_t               id_ex_cmpop,
    input  wb_sel_t               id_ex_wb_sel,
    input  logic                  id_ex_wb_en,
    input  logic                  id_ex_mem_rd,
    input  logic                  id_ex_mem_wr,
    input  logic                  id_ex_illegal,
    output logic                  out_valid,
    output logic [`XLEN-1:0]      out_pc,
    output logic [`XLEN-1:0]      out_pc_next,
    output logic [`XLEN-1:0]      out_order,
    output logic [`REG_IDX_W-1:0] out_rd,
    output logic [`XLEN-1:0]      out_alu,
    output logic                  out_br_en,
    output logic [`XLEN-1:0]      out_rs2_v,
    output wb_sel_t               out_wb_sel,
    output logic                  out_wb_en,
    output logic                  out_mem_rd,
    output logic                  out_mem_wr,
    output logic                  out_illegal
);

    logic [`XLEN-1:0] alu_a, alu_b, cmp_b, alu_out;
    logic             br_en;

    assign alu_a = (id_ex_alu_m1_sel == pc_out) ? id_ex_pc : id_ex_rs1_v;
    assign alu_b = (id_ex_alu_m2_sel == rs2_out) ? id_ex_rs2_v : id_ex_imm;  // imm kind fixed in decode
    assign cmp_b = (id_ex_cmp_sel == i_imm_m_cmp) ? id_ex_imm : id_ex_rs2_v;

    alu alu_i (
        .aluop  (id_ex_aluop),
        .a      (alu_a),
        .b      (alu_b),
        .aluout (alu_out)
    );

    cmp cmp_i (
        .cmpop (id_ex_cmpop),
        .a     (id_ex_rs1_v),
        .b     (cmp_b),
        .br_en (br_en)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            out_wb_en  <= 1'b0;
            out_mem_rd <= 1'b0;
            out_mem_wr <= 1'b0;
        end else begin
            out_valid  <= id_ex_valid;
            out_wb_en  <= id_ex_wb_en;
            out_mem_rd <= id_ex_mem_rd;
            out_mem_wr <= id_ex_mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        out_pc      <= id_ex_pc;
        out_pc_next <= id_ex_pc_next;
        out_order   <= id_ex_order;
        out_rd      <= id_ex_rd;
        out_alu     <= alu_out;  // result, address or branch target
        out_br_en   <= br_en;
        out_rs2_v   <= id_ex_rs2_v;  // store data
        out_wb_sel  <= id_ex_wb_sel;
        out_illegal <= id_ex_illegal;
    end

    valid_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(out_valid));

    store_no_writeback: assert property (@(posedge clk) disable iff (rst)
        out_mem_wr |-> !out_wb_en);

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv32i_config.svh"

module decode_stage
import rv32i_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic [31:0]           in_inst,
    input  logic [`XLEN-1:0]      in_pc,
    input  logic [`XLEN-1:0]      in_order,
    input  logic [`XLEN-1:0]      in_rs1_v,
    input  logic [`XLEN-1:0]      in_rs2_v,
    output logic                  id_ex_valid,
    output logic [`XLEN-1:0]      id_ex_pc,
    output logic [`XLEN-1:0]      id_ex_pc_next,
    output logic [`XLEN-1:0]      id_ex_order,
    output logic [`REG_IDX_W-1:0] id_ex_rd,
    output logic [`XLEN-1:0]      id_ex_rs1_v,
    output logic [`XLEN-1:0]      id_ex_rs2_v,
    output logic [`XLEN-1:0]      id_ex_imm,
    output alu_m1_sel_t           id_ex_alu_m1_sel,
    output alu_m2_sel_t           id_ex_alu_m2_sel,
    output cmp_sel_t              id_ex_cmp_sel,
    output alu_op_t               id_ex_aluop,
    output cmp_op_t               id_ex_cmpop,
    output wb_sel_t               id_ex_wb_sel,
    output logic                  id_ex_wb_en,
    output logic                  id_ex_mem_rd,
    output logic                  id_ex_mem_wr,
    output logic                  id_ex_illegal
);

    opcode_t                opcode;
    logic [2:0]             funct3;
    logic [`REG_IDX_W-1:0]  rd;
    logic [`XLEN-1:0]       i_imm, s_imm, b_imm, u_imm, j_imm, imm;
    alu_m1_sel_t            m1_sel;
    alu_m2_sel_t            m2_sel;
    cmp_sel_t               cmp_sel;
    alu_op_t                aluop;
    cmp_op_t                cmpop;
    wb_sel_t                wb_sel;
    logic                   wb_en, mem_rd, mem_wr, illegal;

    // funct3 plus the inst[30] modifier picks the arithmetic op
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            3'b111:  arith_op = alu_and;
            default: arith_op = alu_add;
        endcase
    endfunction

    function automatic cmp_op_t branch_op(input logic [2:0] f3);
        case (f3)
            3'b001:  branch_op = bne;
            3'b100:  branch_op = blt;
            3'b101:  branch_op = bge;
            3'b110:  branch_op = bltu;
            3'b111:  branch_op = bgeu;
            default: branch_op = beq;
        endcase
    endfunction

    assign opcode = opcode_t'(in_inst[6:0]);
    assign funct3 = in_inst[14:12];
    assign rd     = in_inst[11:7];

    assign i_imm = {{(`XLEN-11){in_inst[31]}}, in_inst[30:20]};
    assign s_imm = {{(`XLEN-11){in_inst[31]}}, in_inst[30:25], in_inst[11:7]};
    assign b_imm = {{(`XLEN-12){in_inst[31]}}, in_inst[7], in_inst[30:25], in_inst[11:8], 1'b0};
    assign u_imm = {in_inst[31:12], 12'h000};
    assign j_imm = {{(`XLEN-20){in_inst[31]}}, in_inst[19:12], in_inst[20], in_inst[30:21], 1'b0};

    always_comb begin
        m1_sel  = rs1_out;
        m2_sel  = i_imm_m;
        cmp_sel = rs2_out_cmp;
        aluop   = alu_add;
        cmpop   = beq;
        wb_sel  = wb_alu;
        wb_en   = 1'b1;
        mem_rd  = 1'b0;
        mem_wr  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            op_lui: begin
                m2_sel = u_imm_m;
                aluop  = alu_pass_b;
            end
            op_auipc: begin
                m1_sel = pc_out;
                m2_sel = u_imm_m;
            end
            op_jal: begin
                m1_sel = pc_out;
                m2_sel = j_imm_m;
                wb_sel = wb_pc_next;
            end
            op_jalr: wb_sel = wb_pc_next;  // target is rs1 + i_imm
            op_br: begin
                m1_sel = pc_out;          // alu gives the target
                m2_sel = b_imm_m;
                cmpop  = branch_op(funct3);
                wb_sel = wb_none;
                wb_en  = 1'b0;
            end
            op_load: begin
                wb_sel = wb_mem;
                mem_rd = 1'b1;
            end
            op_store: begin
                m2_sel = s_imm_m;
                wb_sel = wb_none;
                wb_en  = 1'b0;
                mem_wr = 1'b1;
            end
            op_imm: begin
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    cmp_sel = i_imm_m_cmp;
                    cmpop   = funct3[0] ? bltu : blt;
                    wb_sel  = wb_cmp;
                end else begin
                    // inst[30] is immediate data except for srai
                    aluop = arith_op(funct3, (funct3 == 3'b101) & in_inst[30]);
                end
            end
            op_reg: begin
                m2_sel = rs2_out;
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    cmpop  = funct3[0] ? bltu : blt;
                    wb_sel = wb_cmp;
                end else begin
                    aluop = arith_op(funct3, in_inst[30]);
                end
            end
            default: begin
                illegal = 1'b1;
                wb_sel  = wb_none;
                wb_en   = 1'b0;
            end
        endcase
        if (rd == '0)
            wb_en = 1'b0;  // x0 is never written
    end

    // one immediate travels on, chosen by the m2 select
    always_comb begin
        case (m2_sel)
            u_imm_m: imm = u_imm;
            s_imm_m: imm = s_imm;
            b_imm_m: imm = b_imm;
            j_imm_m: imm = j_imm;
            default: imm = i_imm;  // also feeds slti/sltiu compare
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex_valid  <= 1'b0;
            id_ex_wb_en  <= 1'b0;
            id_ex_mem_rd <= 1'b0;
            id_ex_mem_wr <= 1'b0;
        end else begin
            id_ex_valid  <= in_valid;
            id_ex_wb_en  <= in_valid & wb_en;  // empty slots carry no enables
            id_ex_mem_rd <= in_valid & mem_rd;
            id_ex_mem_wr <= in_valid & mem_wr;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_pc         <= in_pc;
        id_ex_pc_next    <= in_pc + `XLEN'(`INST_BYTES);
        id_ex_order      <= in_order;
        id_ex_rd         <= rd;
        id_ex_rs1_v      <= in_rs1_v;
        id_ex_rs2_v      <= in_rs2_v;
        id_ex_imm        <= imm;
        id_ex_alu_m1_sel <= m1_sel;
        id_ex_alu_m2_sel <= m2_sel;
        id_ex_cmp_sel    <= cmp_sel;
        id_ex_aluop      <= aluop;
        id_ex_cmpop      <= cmpop;
        id_ex_wb_sel     <= wb_sel;
        id_ex_illegal    <= illegal;
    end

    illegal_no_side_effects: assert property (@(posedge clk) disable iff (rst)
        (id_ex_valid && id_ex_illegal) |-> !(id_ex_wb_en || id_ex_mem_rd || id_ex_mem_wr));

endmodule

`default_nettype wire

// File: hdl/cmp.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv32i_config.svh"

module cmp
import rv32i_pkg::*;
(
    input  cmp_op_t            cmpop,
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    output logic               br_en
);

    logic lt_s, lt_u;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    // blt/bltu double as slt/sltu
    always_comb begin
        case (cmpop)
            beq:     br_en = (a == b);
            bne:     br_en = (a != b);
            blt:     br_en = lt_s;
            bge:     br_en = !lt_s;
            bltu:    br_en = lt_u;
            bgeu:    br_en = !lt_u;
            default: br_en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv32i_config.svh"

module alu
import rv32i_pkg::*;
(
    input  alu_op_t            aluop,
    input  logic [`XLEN-1:0]   a,
    input  logic [`XLEN-1:0]   b,
    output logic [`XLEN-1:0]   aluout
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32i shifts ignore the upper bits

    always_comb begin
        case (aluop)
            alu_add:    aluout = a + b;
            alu_sub:    aluout = a - b;
            alu_sll:    aluout = a << shamt;
            alu_srl:    aluout = a >> shamt;
            alu_sra:    aluout = $unsigned($signed(a) >>> shamt);
            alu_xor:    aluout = a ^ b;
            alu_or:     aluout = a | b;
            alu_and:    aluout = a & b;
            alu_pass_b: aluout = b;
            default:    aluout = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic {
        rs1_out,
        pc_out
    } alu_m1_sel_t;

    typedef enum logic [2:0] {
        rs2_out,
        u_imm_m,
        i_imm_m,
        s_imm_m,
        b_imm_m,
        j_imm_m
    } alu_m2_sel_t;

    typedef enum logic {
        rs2_out_cmp,
        i_imm_m_cmp
    } cmp_sel_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_xor,
        alu_or,
        alu_and,
        alu_pass_b  // lui
    } alu_op_t;

    // encodings follow branch funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic [2:0] {
        wb_alu,
        wb_cmp,      // slt, sltu
        wb_pc_next,  // jal, jalr
        wb_mem,
        wb_none
    } wb_sel_t;

endpackage

`default_nettype wire

// File: hdl/rv32i_config.svh
`ifndef RV32I_CONFIG_SVH
`define RV32I_CONFIG_SVH

// data and address width
`define XLEN 32

// register index width, x0..x31
`define REG_IDX_W 5

// pc step between sequential instructions
`define INST_BYTES 4

`endif
